//--- logic/datapath_config.svh
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of one bus word and of every 32-bit register.
`define DATA_WIDTH 32

// number of general registers, R0 to R15.
`define REG_COUNT 16

// ALU opcode and bus source select widths.
`define OPCODE_WIDTH 5
`define SEL_WIDTH 5

`endif

//--- logic/busTypesPkg.sv
`include "datapath_config.svh"

package busTypesPkg;

  localparam int regCount = `REG_COUNT;

  typedef logic [`DATA_WIDTH-1:0] busWord;
  typedef logic [2*`DATA_WIDTH-1:0] doubleWord;
  typedef logic [`REG_COUNT-1:0] regStrobe;
  typedef logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] regBank;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIndex;

  // which block currently owns the shared bus.
  typedef enum logic [`SEL_WIDTH-1:0] {
    srcNone,
    srcReg,
    srcPc,
    srcMdr,
    srcHi,
    srcLo,
    srcZHigh,
    srcZLow,
    srcIr
  } busSource;

endpackage

//--- logic/aluOpsPkg.sv
`include "datapath_config.svh"

package aluOpsPkg;

  typedef enum logic [`OPCODE_WIDTH-1:0] {
    opAdd = 5'b00011,
    opSub = 5'b00100,
    opAnd = 5'b00101,
    opOr  = 5'b00110,
    opShr = 5'b00111,
    opShl = 5'b01000,
    opRor = 5'b01001,
    opRol = 5'b01010,
    opMul = 5'b01111,
    opDiv = 5'b10000,
    opNeg = 5'b10001,
    opNot = 5'b10010
  } aluOp;

  typedef logic signed [`DATA_WIDTH-1:0] signedWord;
  typedef logic signed [2*`DATA_WIDTH-1:0] signedDouble;
  typedef logic [$clog2(`DATA_WIDTH)-1:0] shiftAmount;

  // most negative word, the one dividend whose quotient by -1 overflows.
  localparam signedWord minSigned = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

endpackage

//--- logic/registerFile.sv
`timescale 1ns/1ns

module registerFile import busTypesPkg::*; (
  input  logic     Clock,
  input  logic     rst,
  input  busWord   busData,
  input  regStrobe Rin,
  input  logic     HIin,
  input  logic     LOin,
  output regBank   regValues,
  output busWord   hiValue,
  output busWord   loValue
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // general registers R0 to R15.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each register has its own in-strobe bit, so several may load
  // the same bus word in one cycle.
  always_ff @(posedge Clock) begin
    if (rst) begin
      regValues <= '0;
    end else begin
      for (int i = 0; i < regCount; i++) begin
        if (Rin[i]) begin
          regValues[i] <= busData;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // HI and LO.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // these hold the Z halves once the controller moves them off the bus.
  always_ff @(posedge Clock) begin
    if (rst) begin
      hiValue <= '0;
      loValue <= '0;
    end else begin
      if (HIin) begin
        hiValue <= busData;
      end
      if (LOin) begin
        loValue <= busData;
      end
    end
  end

endmodule

//--- logic/fetchRegisters.sv
`timescale 1ns/1ns

module fetchRegisters import busTypesPkg::*; (
  input  logic   Clock,
  input  logic   rst,
  input  busWord busData,
  input  busWord Mdatain,
  input  logic   Read,
  input  logic   MDRin,
  input  logic   PCin,
  input  logic   IncPC,
  input  logic   IRin,
  input  logic   MARin,
  output busWord pcValue,
  output busWord mdrValue,
  output busWord irValue,
  output busWord marAddress
);

  busWord mdrNext;
  busWord pcNext;

  // memory data wins over the bus while a read is in progress.
  assign mdrNext = Read ? Mdatain : busData;

  // the incrementer is local to PC, so PC+1 never needs the bus or the ALU.
  assign pcNext = IncPC ? pcValue + busWord'(1) : busData;

  always_ff @(posedge Clock) begin
    if (rst) begin
      pcValue    <= '0;
      mdrValue   <= '0;
      irValue    <= '0;
      marAddress <= '0;
    end else begin
      if (PCin) begin
        pcValue <= pcNext;
      end
      if (MDRin) begin
        mdrValue <= mdrNext;
      end
      // IR is only stored here, decode lives in the controller.
      if (IRin) begin
        irValue <= busData;
      end
      if (MARin) begin
        marAddress <= busData;
      end
    end
  end

endmodule

//--- logic/busEncoder.sv
`timescale 1ns/1ns

module busEncoder import busTypesPkg::*; (
  input  regStrobe  Rout,
  input  logic      PCout,
  input  logic      MDRout,
  input  logic      IRout,
  input  logic      HIout,
  input  logic      LOout,
  input  logic      Zhighout,
  input  logic      Zlowout,
  input  regBank    regValues,
  input  busWord    pcValue,
  input  busWord    mdrValue,
  input  busWord    irValue,
  input  busWord    hiValue,
  input  busWord    loValue,
  input  doubleWord zValue,
  output busWord    busData
);

  busSource source;
  regIndex  regSel;

  // the lowest numbered register wins if the controller raises two Rout bits.
  always_comb begin
    regSel = '0;
    for (int i = regCount - 1; i >= 0; i--) begin
      if (Rout[i]) begin
        regSel = regIndex'(i);
      end
    end
  end

  always_comb begin
    if (|Rout)         source = srcReg;
    else if (PCout)    source = srcPc;
    else if (MDRout)   source = srcMdr;
    else if (HIout)    source = srcHi;
    else if (LOout)    source = srcLo;
    else if (Zhighout) source = srcZHigh;
    else if (Zlowout)  source = srcZLow;
    else if (IRout)    source = srcIr;
    else               source = srcNone;
  end

  // a plain mux replaces the tri-state bus, idle reads as zero.
  always_comb begin
    case (source)
      srcReg:   busData = regValues[regSel];
      srcPc:    busData = pcValue;
      srcMdr:   busData = mdrValue;
      srcHi:    busData = hiValue;
      srcLo:    busData = loValue;
      srcZHigh: busData = zValue[2*$bits(busWord)-1:$bits(busWord)];
      srcZLow:  busData = zValue[$bits(busWord)-1:0];
      srcIr:    busData = irValue;
      default:  busData = '0;
    endcase
  end

endmodule

//--- logic/aluStage.sv
`timescale 1ns/1ns

module aluStage import busTypesPkg::*, aluOpsPkg::*; (
  input  logic      Clock,
  input  logic      rst,
  input  busWord    busData,
  input  logic      Yin,
  input  logic      Zin,
  input  aluOp      opcode,
  output doubleWord zValue
);

  busWord      yValue;
  signedWord   opA;
  signedWord   opB;
  shiftAmount  amount;
  doubleWord   doubled;
  signedDouble product;
  signedWord   quotient;
  signedWord   remainder;
  doubleWord   aluResult;

  // operand A waits in Y while operand B arrives on the bus.
  always_ff @(posedge Clock) begin
    if (rst) begin
      yValue <= '0;
    end else if (Yin) begin
      yValue <= busData;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign opA     = signedWord'(yValue);
  assign opB     = signedWord'(busData);
  assign amount  = shiftAmount'(busData);
  assign doubled = {yValue, yValue};
  assign product = signedDouble'(opA) * signedDouble'(opB);

  // divide by zero returns all ones and leaves the dividend as remainder.
  // the overflow case wraps to the dividend like the hardware would.
  always_comb begin
    if (opB == '0) begin
      quotient  = '1;
      remainder = opA;
    end else if (opA == minSigned && &opB) begin
      quotient  = opA;
      remainder = '0;
    end else begin
      quotient  = opA / opB;
      remainder = opA % opB;
    end
  end

  // single-word results sit in the low half with the high half cleared.
  always_comb begin
    aluResult = '0;
    case (opcode)
      opAdd: aluResult[$bits(busWord)-1:0] = yValue + busData;
      opSub: aluResult[$bits(busWord)-1:0] = yValue - busData;
      opAnd: aluResult[$bits(busWord)-1:0] = yValue & busData;
      opOr:  aluResult[$bits(busWord)-1:0] = yValue | busData;
      opShr: aluResult[$bits(busWord)-1:0] = yValue >> amount;
      opShl: aluResult[$bits(busWord)-1:0] = yValue << amount;
      // rotates shift a doubled copy so the bits that fall out wrap around.
      opRor: aluResult[$bits(busWord)-1:0] = busWord'(doubled >> amount);
      opRol: aluResult[$bits(busWord)-1:0] = busWord'((doubled << amount) >> $bits(busWord));
      opMul: aluResult = doubleWord'(product);
      opDiv: aluResult = {busWord'(remainder), busWord'(quotient)};
      opNeg: aluResult[$bits(busWord)-1:0] = busWord'(-opB);
      opNot: aluResult[$bits(busWord)-1:0] = ~busData;
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge Clock) begin
    if (rst) begin
      zValue <= '0;
    end else if (Zin) begin
      zValue <= aluResult;
    end
  end

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ns
`include "datapath_config.svh"

module datapath import busTypesPkg::*, aluOpsPkg::*; (
  input  logic     Clock,
  input  logic     rst,
  input  busWord   Mdatain,
  input  logic     Read,
  input  logic     IncPC,
  input  regStrobe Rin,
  input  regStrobe Rout,
  input  logic     PCin,
  input  logic     IRin,
  input  logic     MARin,
  input  logic     MDRin,
  input  logic     Yin,
  input  logic     Zin,
  input  logic     HIin,
  input  logic     LOin,
  input  logic     PCout,
  input  logic     MDRout,
  input  logic     IRout,
  input  logic     HIout,
  input  logic     LOout,
  input  logic     Zhighout,
  input  logic     Zlowout,
  input  aluOp     opcode,
  output busWord   busData,
  output busWord   marAddress
);

  regBank    regValues;
  busWord    hiValue;
  busWord    loValue;
  busWord    pcValue;
  busWord    mdrValue;
  busWord    irValue;
  doubleWord zValue;

  // every block listens to the one bus, only busEncoder drives it.
  registerFile regs (.Clock, .rst, .busData, .Rin, .HIin, .LOin,
                     .regValues, .hiValue, .loValue);

  fetchRegisters fetch (.Clock, .rst, .busData, .Mdatain, .Read, .MDRin, .PCin,
                        .IncPC, .IRin, .MARin, .pcValue, .mdrValue, .irValue,
                        .marAddress);

  busEncoder encoder (.Rout, .PCout, .MDRout, .IRout, .HIout, .LOout, .Zhighout,
                      .Zlowout, .regValues, .pcValue, .mdrValue, .irValue,
                      .hiValue, .loValue, .zValue, .busData);

  aluStage alu (.Clock, .rst, .busData, .Yin, .Zin, .opcode, .zValue);

endmodule

//--- sim/datapath_assert.sv
`timescale 1ns/1ns

module datapathAssert import busTypesPkg::*; (
  input logic     Clock,
  input logic     rst,
  input regStrobe Rout,
  input logic     PCout, MDRout, IRout, HIout, LOout, Zhighout, Zlowout,
  input logic     Zin,
  input busWord   busData
);

  logic [$bits(regStrobe)+6:0] outStrobes;

  assign outStrobes = {Rout, PCout, MDRout, IRout, HIout, LOout, Zhighout, Zlowout};

  // the shared bus has at most one driver in any cycle.
  singleDriver: assert property (@(posedge Clock) disable iff (rst)
    $countones(outStrobes) <= 1)
    else $error("more than one out-strobe is high");

  idleBusZero: assert property (@(posedge Clock) disable iff (rst)
    outStrobes == '0 |-> busData == '0)
    else $error("busData is not zero while no out-strobe is high");

  zLoadNotRead: assert property (@(posedge Clock) disable iff (rst)
    !(Zin && (Zhighout || Zlowout)))
    else $error("Zin is high together with a Z out-strobe");

endmodule

bind datapath datapathAssert checks (
  .Clock, .rst, .Rout, .PCout, .MDRout, .IRout, .HIout, .LOout,
  .Zhighout, .Zlowout, .Zin, .busData
);

//--- sim/datapathTb.sv
`timescale 1ns/1ns
`include "datapath_config.svh"

module datapathTb import busTypesPkg::*, aluOpsPkg::*; ();

  localparam int W = `DATA_WIDTH;

  logic      Clock;
  logic      rst;
  busWord    Mdatain;
  logic      Read, IncPC;
  regStrobe  Rin, Rout;
  logic      PCin, IRin, MARin, MDRin, Yin, Zin, HIin, LOin;
  logic      PCout, MDRout, IRout, HIout, LOout, Zhighout, Zlowout;
  aluOp      opcode;
  busWord    busData, marAddress;
  busWord    rngState = 32'h2be9_ae0f;
  busWord    regModel [`REG_COUNT];
  doubleWord lastZ;

  datapath UUT (.*);

  initial begin
    Clock = 1'b0;
    forever #5 Clock = ~Clock;
  end

  function automatic busWord nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // expected Z for one operation, with A taken from Y and B from the bus.
  function automatic doubleWord aluModel(aluOp op, busWord a, busWord b);
    busWord    magA = a[W-1] ? ~a + busWord'(1) : a;
    busWord    magB = b[W-1] ? ~b + busWord'(1) : b;
    busWord    quot;
    busWord    rem;
    int        s = int'(b[4:0]);
    doubleWord r = '0;
    case (op)
      opAdd: r[W-1:0] = a + b;
      opSub: r[W-1:0] = a - b;
      opAnd: r[W-1:0] = a & b;
      opOr:  r[W-1:0] = a | b;
      opShr: r[W-1:0] = a >> s;
      opShl: r[W-1:0] = a << s;
      opRor: r[W-1:0] = (a >> s) | (a << (W - s));
      opRol: r[W-1:0] = (a << s) | (a >> (W - s));
      opMul: r = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
      opDiv: begin
        if (b == '0) begin
          r = {a, {W{1'b1}}};
        end else begin
          // divide the magnitudes, then the quotient takes the sign of the
          // product and the remainder the sign of the dividend.
          quot = magA / magB;
          rem  = magA % magB;
          if (a[W-1] != b[W-1]) begin
            quot = ~quot + busWord'(1);
          end
          if (a[W-1]) begin
            rem = ~rem + busWord'(1);
          end
          r = {rem, quot};
        end
      end
      opNeg: r[W-1:0] = ~b + busWord'(1);
      opNot: r[W-1:0] = ~b;
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic stopOnFailure(string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic checkValue(string name, busWord got, busWord want);
    if (got !== want) begin
      stopOnFailure($sformatf("** Error %s: got %h, expected %h", name, got, want));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus sequencing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // strobes last exactly one cycle, so each edge drops all of them.
  task automatic tick();
    @(posedge Clock);
    #1;
    {Read, IncPC, Rin, Rout} = '0;
    {PCin, IRin, MARin, MDRin, Yin, Zin, HIin, LOin} = '0;
    {PCout, MDRout, IRout, HIout, LOout, Zhighout, Zlowout} = '0;
  endtask

  task automatic sampleBus(string name, busWord want);
    #2;
    checkValue(name, busData, want);
    tick();
  endtask

  task automatic loadRegister(regIndex idx, busWord value);
    Mdatain = value;
    Read = 1'b1;
    MDRin = 1'b1;
    tick();
    MDRout = 1'b1;
    Rin = regStrobe'(1) << idx;
    tick();
    regModel[idx] = value;
  endtask

  task automatic runAlu(aluOp op, busWord a, busWord b);
    loadRegister(1, a);
    loadRegister(2, b);
    Rout[1] = 1'b1;
    Yin = 1'b1;
    tick();
    Rout[2] = 1'b1;
    Zin = 1'b1;
    opcode = op;
    tick();
    lastZ = aluModel(op, a, b);
    Zlowout = 1'b1;
    sampleBus($sformatf("busData Zlow %s", op.name()), lastZ[W-1:0]);
    Zhighout = 1'b1;
    sampleBus($sformatf("busData Zhigh %s", op.name()), lastZ[2*W-1:W]);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic testIdleBus();
    checkValue("busData idle", busData, '0);
    for (int i = 0; i < `REG_COUNT; i++) begin
      Rout = regStrobe'(1) << i;
      sampleBus($sformatf("busData R%0d after reset", i), '0);
    end
    for (int k = 0; k < 5; k++) begin
      {PCout, MDRout, HIout, LOout, Zlowout} = 5'b1 << k;
      sampleBus($sformatf("busData source %0d after reset", k), '0);
    end
  endtask

  task automatic testRegisterTransfer();
    for (int i = 0; i < `REG_COUNT; i++) begin
      loadRegister(regIndex'(i), nextRandom());
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      Rout = regStrobe'(1) << i;
      sampleBus($sformatf("busData R%0d", i), regModel[regIndex'(i)]);
    end
  endtask

  task automatic testFetchPath();
    busWord oldPc = regModel[3];
    Rout[3] = 1'b1;
    PCin = 1'b1;
    tick();
    PCout = 1'b1;
    MARin = 1'b1;
    tick();
    checkValue("marAddress", marAddress, oldPc);
    IncPC = 1'b1;
    PCin = 1'b1;
    tick();
    PCout = 1'b1;
    sampleBus("busData PC", oldPc + busWord'(1));
    // MDR still holds the word last read for R15.
    MDRout = 1'b1;
    IRin = 1'b1;
    tick();
    IRout = 1'b1;
    sampleBus("busData IR", regModel[`REG_COUNT-1]);
  endtask

  task automatic testAluOps();
    aluOp op = opAdd;
    do begin
      runAlu(op, nextRandom(), nextRandom());
      runAlu(op, nextRandom(), nextRandom());
      op = op.next();
    end while (op != opAdd);
    runAlu(opDiv, busWord'(-21), busWord'(-5));
  endtask

  task automatic testCorners();
    aluOp shiftOp = opShr;
    runAlu(opDiv, nextRandom(), '0);
    runAlu(opMul, 32'h8000_0000, 32'hffff_ffff);
    // shr, shl, ror and rol sit next to each other in the opcode enum.
    repeat (4) begin
      runAlu(shiftOp, nextRandom(), nextRandom() & 32'hffff_ffe0);
      runAlu(shiftOp, nextRandom(), nextRandom() | 32'h0000_001f);
      shiftOp = shiftOp.next();
    end
  endtask

  task automatic testHiLo();
    runAlu(opMul, nextRandom(), nextRandom());
    Zlowout = 1'b1;
    LOin = 1'b1;
    tick();
    Zhighout = 1'b1;
    HIin = 1'b1;
    tick();
    LOout = 1'b1;
    sampleBus("busData LO", lastZ[W-1:0]);
    HIout = 1'b1;
    sampleBus("busData HI", lastZ[2*W-1:W]);
  endtask

  initial begin
    int cycles = 0;
    rst = 1'b1;
    Mdatain = '0;
    opcode = opAdd;
    {Read, IncPC, Rin, Rout} = '0;
    {PCin, IRin, MARin, MDRin, Yin, Zin, HIin, LOin} = '0;
    {PCout, MDRout, IRout, HIout, LOout, Zhighout, Zlowout} = '0;
    repeat (4) @(posedge Clock);
    #1;
    rst = 1'b0;
    while (marAddress !== '0) begin
      tick();
      cycles++;
      if (cycles > 8) begin
        stopOnFailure("marAddress did not clear after reset");
      end
    end
    testIdleBus();
    testRegisterTransfer();
    testFetchPath();
    testAluOps();
    testCorners();
    testHiLo();
    $display("test passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+logic
logic/busTypesPkg.sv
logic/aluOpsPkg.sv
logic/registerFile.sv
logic/fetchRegisters.sv
logic/busEncoder.sv
logic/aluStage.sv
logic/datapath.sv
sim/datapath_assert.sv
sim/datapathTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module datapathTb -f project.f \
  -Mdir obj_dir -o datapathSim

./obj_dir/datapathSim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  exit 1
fi
